// File: issue_core.f
logic/issue_pkg.sv
logic/fetch_buffer.sv
logic/hazard_detection.sv
logic/decode_stage.sv
logic/issue_port.sv
logic/issue_core.sv
test/issue_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the issue_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --top-module issue_core_tb -f issue_core.f \
	--Mdir "$BUILD" -o issue_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD/issue_core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "Simulation PASSED"
exit 0

// File: test/issue_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_core_tb;

	localparam int N_STIM = 17;                 // Program length.
	localparam int LIMIT  = N_STIM * 8 + 50;    // Cycles allowed per run.
	localparam int TAIL   = 4;                  // Cycles watched after the last issue.

	logic              clk;
	logic              rst_n;
	logic              in_valid;
	issue_pkg::instr_u in_instr;
	logic              in_ready;
	logic              out_valid;
	issue_pkg::instr_u out_instr;
	logic              out_ready;
	logic              halted;

	issue_pkg::instr_u stim_word [N_STIM];      // Words in program order.
	logic              stim_lu   [N_STIM];      // Load-use with the word before.
	logic              stim_halt [N_STIM];      // Halt entry.
	issue_pkg::instr_u expect_q  [$];           // Accepted, not yet issued.
	logic [31:0]       rng_state;               // Back-pressure generator.

	issue_core #(.HALT_DRAIN(3)) dut0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_instr (in_instr),
		.in_ready (in_ready),
		.out_valid(out_valid),
		.out_instr(out_instr),
		.out_ready(out_ready),
		.halted   (halted)
	);

	always #20 clk = ~clk;                      // 40 ns period.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model and helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Store, LHB and LLB read bits 11:8 and the rest read bits 7:4.
	function automatic logic [3:0] first_read_reg(input logic [15:0] w);
		logic [3:0] op;
		op = w[15:12];
		return (op == 4'b1001 || op == 4'b1010 || op == 4'b1011) ? w[11:8] : w[7:4];
	endfunction

	// A load followed by a reader of its low nibble.
	function automatic logic load_use_pair(input logic [15:0] prev, input logic [15:0] cur);
		return (prev[15:12] == 4'b1000) &&
			((first_read_reg(cur) == prev[3:0]) || (cur[3:0] == prev[3:0]));
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_instr(input issue_pkg::instr_u actual,
		input issue_pkg::instr_u expected, input string what);
		if (actual !== expected) begin          // Every bit of both views.
			stop_with_failure($sformatf("[ERROR] %0t ns: %s is %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			stop_with_failure($sformatf("[ERROR] %0t ns: %s is %b, expected %b",
				$time, what, actual, expected));
		end
	endtask

	task automatic set_entry(input int k, input logic [15:0] w, input logic lu,
		input logic hlt);
		stim_word[k] = w;
		stim_lu[k]   = lu;
		stim_halt[k] = hlt;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic fill_table();
		set_entry(0,  16'h1123, 1'b0, 1'b0);    // Plain ALU op.
		set_entry(1,  16'h8405, 1'b0, 1'b0);    // Load r5.
		set_entry(2,  16'h2656, 1'b1, 1'b0);    // Reads r5 through rs.
		set_entry(3,  16'h8407, 1'b0, 1'b0);    // Load r7.
		set_entry(4,  16'h3217, 1'b1, 1'b0);    // Reads r7 through rt.
		set_entry(5,  16'h8409, 1'b0, 1'b0);    // Load r9.
		set_entry(6,  16'h9923, 1'b1, 1'b0);    // Store reads r9 from 11:8.
		set_entry(7,  16'h840A, 1'b0, 1'b0);    // Load rA.
		set_entry(8,  16'hA3A5, 1'b0, 1'b0);    // LHB with A only in bits 7:4.
		set_entry(9,  16'h840C, 1'b0, 1'b0);    // Load rC.
		set_entry(10, 16'hBC12, 1'b1, 1'b0);    // LLB reads rC from 11:8.
		set_entry(11, 16'h4CC1, 1'b0, 1'b0);    // Reader after a non-load.
		set_entry(12, 16'h8403, 1'b0, 1'b0);    // Load r3.
		set_entry(13, 16'h5100, 1'b0, 1'b0);    // Independent of r3.
		set_entry(14, 16'h8408, 1'b0, 1'b0);    // Load r8.
		set_entry(15, 16'h8088, 1'b1, 1'b0);    // Load reading r8.
		set_entry(16, 16'hF000, 1'b0, 1'b1);    // Halt.
	endtask

	// One program from reset to halt.
	task automatic run_program(input logic fixed_ready);
		int                idx;
		int                issued;
		int                cycles;
		int                last_issue;
		int                tail;
		logic              halt_acc;
		logic              halt_iss;
		issue_pkg::instr_u expected;
		idx        = 0;
		issued     = 0;
		cycles     = 0;
		last_issue = 0;
		tail       = 0;
		halt_acc   = 1'b0;
		halt_iss   = 1'b0;
		expect_q.delete();
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		out_ready = 1'b0;
		repeat (3) @(negedge clk);              // Three reset cycles.
		rst_n = 1'b1;
		#1;
		check_flag(out_valid, 1'b0, "out_valid after reset");
		check_flag(halted, 1'b0, "halted after reset");
		check_flag(in_ready, 1'b1, "in_ready after reset");
		while (tail < TAIL) begin
			@(negedge clk);
			if (fixed_ready) begin
				out_ready = 1'b1;
			end else begin
				rng_state = xorshift32(rng_state);
				out_ready = (rng_state[1:0] != 2'b00);  // Ready three times in four.
			end
			in_valid = (idx < N_STIM);
			if (idx < N_STIM) begin
				in_instr = stim_word[idx];      // Held until accepted.
			end
			#1;                                 // Let the handshake settle.
			cycles++;
			if (cycles > LIMIT) begin
				stop_with_failure("Timeout: the pipeline stopped issuing instructions");
			end
			check_flag(halted, halt_iss, "halted");
			if (halt_acc) begin
				check_flag(in_ready, 1'b0, "in_ready after the halt");
			end
			if (in_valid && in_ready) begin     // Intake at the next edge.
				expect_q.push_back(in_instr);
				if (stim_halt[idx]) begin
					halt_acc = 1'b1;
				end
				idx++;
			end
			if (out_valid && out_ready) begin   // Issue at the next edge.
				if (expect_q.size() == 0) begin
					stop_with_failure("A word was issued that was never accepted");
				end
				expected = expect_q.pop_front();
				check_instr(out_instr, expected, "issued word");
				if (fixed_ready && issued > 0) begin
					check_flag(logic'(cycles - last_issue > 1), stim_lu[issued],
						"bubble before issue");
				end
				halt_iss   = stim_halt[issued];
				last_issue = cycles;
				issued++;
			end
			if (issued == N_STIM) begin
				tail++;                         // Watch the frozen pipe a while.
			end
		end
		in_valid = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_instr  = '0;
		out_ready = 1'b0;
		rng_state = 32'hecba;
		fill_table();
		for (int k = 1; k < N_STIM; k++) begin
			if (load_use_pair(stim_word[k-1], stim_word[k]) !== stim_lu[k]) begin
				stop_with_failure($sformatf("Stimulus entry %0d has a wrong load-use mark", k));
			end
		end
		run_program(1'b1);                      // Exact bubble timing.
		run_program(1'b0);                      // Random back-pressure.
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/issue_core.sv
`timescale 1ns/1ps
`default_nettype none

// Pipeline front: intake, IF/ID, ID/EX, issue.
module issue_core #(
	parameter int HALT_DRAIN = 3                // Advances from halt to halted.
) (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                in_valid,
	input  wire issue_pkg::instr_u in_instr,
	output logic               in_ready,
	output logic               out_valid,
	output issue_pkg::instr_u  out_instr,
	input  wire                out_ready,
	output logic               halted
);

	logic              advance;                 // Whole pipe moves.
	logic              ifid_valid;
	issue_pkg::instr_u ifid_instr;
	logic              idex_valid;
	issue_pkg::instr_u idex_instr;
	logic              idex_memread;
	logic              stall;                   // Load-use or halted.
	logic              halt_seen;               // Intake closed.

	fetch_buffer fetch0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_instr  (in_instr),
		.in_ready  (in_ready),
		.advance   (advance),
		.stall     (stall),
		.halt_seen (halt_seen),
		.ifid_valid(ifid_valid),
		.ifid_instr(ifid_instr)
	);

	hazard_detection #(.HALT_DRAIN(HALT_DRAIN)) hazard0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.ifid_valid  (ifid_valid),
		.ifid_instr  (ifid_instr),
		.idex_instr  (idex_instr),
		.idex_memread(idex_memread),
		.advance     (advance),
		.stall       (stall),
		.halt_seen   (halt_seen),
		.halted      (halted)
	);

	decode_stage decode0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.ifid_valid  (ifid_valid),
		.ifid_instr  (ifid_instr),
		.stall       (stall),
		.advance     (advance),
		.idex_valid  (idex_valid),
		.idex_instr  (idex_instr),
		.idex_memread(idex_memread)
	);

	issue_port issue0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.idex_valid(idex_valid),
		.idex_instr(idex_instr),
		.out_ready (out_ready),
		.out_valid (out_valid),
		.out_instr (out_instr),
		.advance   (advance)
	);

endmodule

`default_nettype wire

// File: logic/issue_port.sv
`timescale 1ns/1ps
`default_nettype none

// Output register toward execute, source of the pipeline advance.
module issue_port (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                idex_valid,      // ID/EX holds a word.
	input  wire issue_pkg::instr_u idex_instr,  // Word in execute.
	input  wire                out_ready,       // Execute accepts.
	output logic               out_valid,       // Issued word present.
	output issue_pkg::instr_u  out_instr,       // Issued word.
	output logic               advance          // Pipeline moves this edge.
);

	logic load_out;                             // Real word into output.

	// Empty slot or a transfer this cycle frees the register.
	assign advance  = ~out_valid | out_ready;
	assign load_out = advance & idex_valid;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (advance) begin
			out_valid <= idex_valid;            // Bubbles stay invisible.
		end
	end

	// Held stable under back-pressure.
	always_ff @(posedge clk) begin
		if (load_out) begin
			out_instr <= idex_instr;
		end
	end

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

// ID/EX register with bubble insertion and memread decode.
module decode_stage (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                ifid_valid,      // IF/ID holds a word.
	input  wire issue_pkg::instr_u ifid_instr,  // Word in decode.
	input  wire                stall,           // Insert a bubble.
	input  wire                advance,         // Pipeline moves this edge.
	output logic               idex_valid,      // ID/EX holds a word.
	output issue_pkg::instr_u  idex_instr,      // Word in execute.
	output logic               idex_memread     // ID/EX holds a load.
);

	logic take_ifid;                            // IF/ID moves in.
	logic is_load;                              // Decoded memread.

	assign take_ifid = advance & ifid_valid & ~stall;
	assign is_load   = (ifid_instr.r.op == issue_pkg::OP_LOAD);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ID/EX control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idex_valid   <= 1'b0;
			idex_memread <= 1'b0;
		end else if (advance) begin
			if (take_ifid) begin
				idex_valid   <= 1'b1;           // Real instruction.
				idex_memread <= is_load;
			end else begin
				idex_valid   <= 1'b0;           // Bubble.
				idex_memread <= 1'b0;           // A bubble never loads.
			end
		end
	end

	// Payload only changes when a real word enters.
	always_ff @(posedge clk) begin
		if (take_ifid) begin
			idex_instr <= ifid_instr;
		end
	end

endmodule

`default_nettype wire

// File: logic/hazard_detection.sv
`timescale 1ns/1ps
`default_nettype none

// Load-use check between IF/ID and ID/EX, and halt draining.
module hazard_detection #(
	parameter int HALT_DRAIN = 3                // Advances from halt to halted.
) (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                ifid_valid,      // IF/ID holds a word.
	input  wire issue_pkg::instr_u ifid_instr,  // Word in decode.
	input  wire issue_pkg::instr_u idex_instr,  // Word in execute.
	input  wire                idex_memread,    // ID/EX holds a load.
	input  wire                advance,         // Pipeline moves this edge.
	output logic               stall,           // Hold IF/ID, bubble ID/EX.
	output logic               halt_seen,       // Halt reached IF/ID.
	output logic               halted           // Sticky, pipe drained.
);

	logic [3:0]            ifid_rs;             // First source of IF/ID.
	logic [3:0]            ifid_rt;             // Second source of IF/ID.
	logic [3:0]            idex_rt;             // Load destination.
	logic                  load_use;            // Data hazard.
	logic                  halt_in_ifid;        // Valid halt in decode.
	logic                  halt_move;           // Halt leaves IF/ID.
	logic                  halt_seen_q;         // Halt was seen earlier.
	logic [HALT_DRAIN-1:0] drain_q;             // Halt drain chain.
	logic                  halted_q;            // Sticky halt flag.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Load-use
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign ifid_rs = issue_pkg::first_source(ifid_instr);
	assign ifid_rt = ifid_instr.r.rt;           // Always bits 3:0.
	assign idex_rt = idex_instr.r.rt;           // Load writes its low nibble.

	// memread is registered, so only compares sit in this path
	assign load_use = ifid_valid & idex_memread &
		((ifid_rs == idex_rt) | (ifid_rt == idex_rt));

	assign stall = load_use | halted;           // Halted freezes the pipe.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Halt
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign halt_in_ifid = ifid_valid & (ifid_instr.r.op == issue_pkg::OP_HALT);
	assign halt_move    = halt_in_ifid & ~load_use;   // Enters ID/EX on advance.
	assign halt_seen    = halt_in_ifid | halt_seen_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halt_seen_q <= 1'b0;
		end else if (halt_in_ifid) begin
			halt_seen_q <= 1'b1;                // Stays set until reset.
		end
	end

	// Drain chain follows the halt down the pipe.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			drain_q <= '0;
		end else if (advance) begin
			drain_q[0] <= halt_move;            // Halt enters ID/EX.
			for (int i = 1; i < HALT_DRAIN; i++) begin
				drain_q[i] <= drain_q[i-1];     // One stage per advance.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halted_q <= 1'b0;
		end else if (drain_q[HALT_DRAIN-1]) begin
			halted_q <= 1'b1;                   // Chain output reached.
		end
	end

	// Rises with the chain output, held by the flag afterwards.
	assign halted = halted_q | drain_q[HALT_DRAIN-1];

endmodule

`default_nettype wire

// File: logic/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// IF/ID register with a valid/ready intake.
// Accepts a word only when the register can also move on this cycle.
module fetch_buffer (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                in_valid,        // Intake word present.
	input  wire issue_pkg::instr_u in_instr,    // Intake word.
	output logic               in_ready,        // Intake may transfer.
	input  wire                advance,         // Pipeline moves this edge.
	input  wire                stall,           // Hold IF/ID.
	input  wire                halt_seen,       // Halt reached IF/ID.
	output logic               ifid_valid,      // IF/ID holds a word.
	output issue_pkg::instr_u  ifid_instr       // IF/ID word.
);

	logic ifid_consumed;                        // Decode takes IF/ID.
	logic ifid_free;                            // Room for a new word.
	logic take;                                 // Intake transfer.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Intake control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign ifid_consumed = advance & ~stall;    // Moves into ID/EX.
	assign ifid_free     = ~ifid_valid | ifid_consumed;

	// A halt in IF/ID closes the intake for good.
	assign in_ready = advance & ~stall & ~halt_seen & ifid_free;
	assign take     = in_valid & in_ready;      // Handshake.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// IF/ID register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ifid_valid <= 1'b0;                 // Empty after reset.
		end else if (take) begin
			ifid_valid <= 1'b1;                 // New word arrives.
		end else if (ifid_consumed) begin
			ifid_valid <= 1'b0;                 // Moved on with nothing behind it.
		end
	end

	// Payload follows the valid bit.
	always_ff @(posedge clk) begin
		if (take) begin
			ifid_instr <= in_instr;
		end
	end

endmodule

`default_nettype wire

// File: logic/issue_pkg.sv
`default_nettype none

package issue_pkg;

	localparam int INSTR_W = 16;                // Instruction word width.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcodes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [3:0] OP_LOAD  = 4'b1000;  // Memory read into rt.
	localparam logic [3:0] OP_STORE = 4'b1001;  // Memory write.
	localparam logic [3:0] OP_LHB   = 4'b1010;  // Load high byte.
	localparam logic [3:0] OP_LLB   = 4'b1011;  // Load low byte.
	localparam logic [3:0] OP_HALT  = 4'b1111;  // Stop the machine.

	// One instruction word, seen as register form or immediate form.
	typedef union packed {
		struct packed {
			logic [3:0] op;                     // Opcode.
			logic [3:0] rd;                     // Destination.
			logic [3:0] rs;                     // First source.
			logic [3:0] rt;                     // Second source.
		} r;
		struct packed {
			logic [3:0]         op;             // Opcode.
			logic [3:0]         rd;             // Register in bits 11:8.
			logic [INSTR_W-9:0] imm;            // Byte immediate.
		} i;
	} instr_u;

	// First source register read by an instruction.
	// Store and the byte loads read bits 11:8, everything else bits 7:4.
	function automatic logic [3:0] first_source(input instr_u instr);
		logic [3:0] src;
		case (instr.r.op)
			OP_STORE, OP_LHB, OP_LLB: src = instr.i.rd;   // Upper register field.
			default:                  src = instr.r.rs;   // Usual rs field.
		endcase
		return src;
	endfunction

endpackage

`default_nettype wire
